// File: dv/fpga_subsystem_checker.sv
`timescale 1ns/1ns
// Concurrent assertions on the subsystem top for servo enables,
// register strobes, status-LED selection and miso idle level
module fpga_subsystem_checker
    import fpga_subsystem_pkg::*;
(
    input logic                  clock,
    input logic                  reset_n,
    input logic                  cs_n,          // SPI chip select pin
    input logic                  miso,
    input logic [ADDR_WIDTH-1:0] address,       // Register bus
    input logic                  write_en,
    input logic [DATA_WIDTH-1:0] wr_data,
    input logic                  read_en,
    input logic [NUM_SERVOS-1:0] servo_enable,
    input logic [NUM_SERVOS-1:0] servo_pwm,
    input logic [NUM_SERVOS-1:0] sr_fault,      // Raw fault pins
    input logic                  status_fault,
    input logic                  status_pi,
    input logic                  status_ps4,
    input logic                  status_debug
);

    logic [DATA_WIDTH-1:0] status_shadow;       // Mirror of status control
    logic                  led_test;

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n)
            status_shadow <= '0;
        else if (write_en && address == ADDR_STATUS_CONTROL)
            status_shadow <= wr_data;
    end

    assign led_test = status_shadow[STATUS_LED_TEST];

    //////////////////////////////
    // Servo and bus strobes
    //////////////////////////////
    a_disabled_low: assert property (@(posedge clock) disable iff (!reset_n)
        (servo_pwm & ~servo_enable) == '0)
        else $error("Disabled servo channel drives a high PWM output");

    a_strobes_exclusive: assert property (@(posedge clock) disable iff (!reset_n)
        !(write_en && read_en))
        else $error("write_en and read_en high in the same cycle");

    a_write_single: assert property (@(posedge clock) disable iff (!reset_n)
        write_en |=> !write_en)
        else $error("write_en held longer than one cycle");

    a_read_single: assert property (@(posedge clock) disable iff (!reset_n)
        read_en |=> !read_en)
        else $error("read_en held longer than one cycle");

    //////////////////////////////
    // Status LEDs and miso
    //////////////////////////////
    // Faults reach the LED through two sync stages
    a_fault_led: assert property (@(posedge clock) disable iff (!reset_n)
        status_fault == (led_test ? status_shadow[STATUS_FAULT_LED] : |$past(sr_fault, 2)))
        else $error("status_fault does not match the LED selection");

    a_pi_ps4_led: assert property (@(posedge clock) disable iff (!reset_n)
        status_pi == (led_test | status_shadow[STATUS_PI]) &&
        status_ps4 == (led_test | status_shadow[STATUS_PS4]))
        else $error("status_pi or status_ps4 does not match the LED selection");

    a_debug_led: assert property (@(posedge clock) disable iff (!reset_n)
        status_debug == (led_test ? status_shadow[STATUS_MOTOR_HOT] : 1'b1))
        else $error("status_debug does not match the LED selection");

    a_miso_idle: assert property (@(posedge clock) disable iff (!reset_n)
        cs_n |-> !miso)
        else $error("miso driven while cs_n is high");

endmodule

bind fpga_subsystem fpga_subsystem_checker u_checker (
    .clock        (clock),
    .reset_n      (reset_n),
    .cs_n         (cs_n),
    .miso         (miso),
    .address      (address),
    .write_en     (write_en),
    .wr_data      (wr_data),
    .read_en      (read_en),
    .servo_enable (servo_enable),
    .servo_pwm    (servo_pwm),
    .sr_fault     (sr_fault),
    .status_fault (status_fault),
    .status_pi    (status_pi),
    .status_ps4   (status_ps4),
    .status_debug (status_debug)
);

// File: dv/tb_fpga_subsystem.sv
`timescale 1ns/1ns
// Testbench for the arm-servo subsystem with clock, reset, SPI host tasks,
// register, servo and LED stimulus and readback compares
module tb_fpga_subsystem
    import fpga_subsystem_pkg::*;
();

    localparam int SPI_HALF      = 4;                           // Clocks per SPI phase
    localparam int PRESCALE      = int'(SERVO_PRESCALE_DEFAULT);
    localparam int PERIOD_CLOCKS = 256 * PRESCALE;              // One PWM period
    localparam int RAMP_PULSES   = 10;                          // Long enough to settle
    localparam logic [31:0] RANDOM_SEED = 32'h2bb9;

    logic                  clock;
    logic                  reset_n;
    logic                  spi_clock;
    logic                  cs_n;
    logic                  mosi;
    logic                  miso;
    logic [NUM_SERVOS-1:0] sr_fault;
    logic [NUM_SERVOS-1:0] servo_pwm;
    logic                  status_fault;
    logic                  status_pi;
    logic                  status_ps4;
    logic                  status_debug;
    int                    check_errors;                        // Wrong values
    int                    timeout_errors;                      // Waits that ran out

    fpga_subsystem dut (
        .clock        (clock),
        .reset_n      (reset_n),
        .spi_clock    (spi_clock),
        .cs_n         (cs_n),
        .mosi         (mosi),
        .miso         (miso),
        .sr_fault     (sr_fault),
        .servo_pwm    (servo_pwm),
        .status_fault (status_fault),
        .status_pi    (status_pi),
        .status_ps4   (status_ps4),
        .status_debug (status_debug)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;                              // 4 ns period
    end

    //////////////////////////////
    // Helpers
    //////////////////////////////
    task automatic check_value(input string name, input int got, input int exp);
        assert (got == exp) else begin
            $display("[FAIL] %s: expected 0x%0h, got 0x%0h", name, exp, got);
            check_errors++;
        end
    endtask

    // One mode-0 frame sent MSB first with miso captured over the second byte
    task automatic spi_frame(input logic [15:0] frame, output logic [DATA_WIDTH-1:0] rx);
        rx = '0;
        @(negedge clock);
        cs_n = 1'b0;
        for (int i = 15; i >= 0; i--) begin
            mosi = frame[i];
            repeat (SPI_HALF) @(negedge clock);
            if (i < 8)
                rx = {rx[DATA_WIDTH-2:0], miso};                // Sample before the rise
            spi_clock = 1'b1;
            repeat (SPI_HALF) @(negedge clock);
            spi_clock = 1'b0;
        end
        repeat (SPI_HALF) @(negedge clock);
        cs_n = 1'b1;
        mosi = 1'b0;
        repeat (SPI_HALF) @(negedge clock);                     // Idle gap
    endtask

    task automatic spi_write(input logic [ADDR_WIDTH-1:0] addr,
                             input logic [DATA_WIDTH-1:0] data);
        logic [DATA_WIDTH-1:0] ignored;
        spi_frame({1'b1, 1'b0, addr, data}, ignored);           // Write flag set
    endtask

    task automatic spi_read(input logic [ADDR_WIDTH-1:0] addr,
                            output logic [DATA_WIDTH-1:0] data);
        spi_frame({1'b0, 1'b0, addr, 8'h00}, data);
    endtask

    task automatic wait_pwm(input int ch, input logic level, output logic ok);
        int n;
        n = 0;
        while (servo_pwm[ch] != level && n < 2 * PERIOD_CLOCKS) begin
            @(negedge clock);
            n++;
        end
        ok = (servo_pwm[ch] == level);
        if (!ok) begin
            $display("Timeout: servo_pwm[%0d] never went to %0d", ch, level);
            timeout_errors++;
        end
    endtask

    // Width in clocks of the next pulse that starts after a low level
    task automatic measure_pulse(input int ch, output int width);
        logic ok;
        width = 0;
        wait_pwm(ch, 1'b0, ok);
        if (ok)
            wait_pwm(ch, 1'b1, ok);
        while (ok && servo_pwm[ch] && width < PERIOD_CLOCKS) begin
            @(negedge clock);
            width++;
        end
        if (ok && servo_pwm[ch]) begin
            $display("Timeout: servo_pwm[%0d] stayed high for a whole period", ch);
            timeout_errors++;
        end
    endtask

    task automatic wait_fault_led(input logic level);
        int n;
        n = 0;
        while (status_fault != level && n < 3) begin              // Two-stage sync lag
            @(negedge clock);
            n++;
        end
        if (status_fault != level) begin
            $display("Timeout: status_fault did not follow sr_fault within 3 clocks");
            timeout_errors++;
        end
    endtask

    //////////////////////////////
    // Stimulus
    //////////////////////////////
    initial begin
        logic [DATA_WIDTH-1:0] data;
        logic [DATA_WIDTH-1:0] written [6];                     // Indexed by address
        logic [DATA_WIDTH-1:0] ctrl;
        logic [DATA_WIDTH-1:0] pos;
        int                    width [RAMP_PULSES];
        int                    ratio;
        int                    ch;
        int                    seed_state;

        seed_state = $urandom(RANDOM_SEED);
        reset_n        = 1'b0;
        spi_clock      = 1'b0;
        cs_n           = 1'b1;
        mosi           = 1'b0;
        sr_fault       = '0;
        check_errors   = 0;
        timeout_errors = 0;
        repeat (10) @(negedge clock);
        reset_n = 1'b1;
        @(negedge clock);

        // Reset values, identity and unmapped reads
        check_value("servo_pwm", int'(servo_pwm), 0);
        check_value("miso", int'(miso), 0);
        check_value("status_fault", int'(status_fault), 0);
        check_value("status_pi", int'(status_pi), 0);
        check_value("status_ps4", int'(status_ps4), 0);
        check_value("status_debug", int'(status_debug), 1);
        spi_read(ADDR_ID, data);
        check_value("rd_data", int'(data), int'(SUBSYSTEM_ID));
        for (int k = 0; k < 3; k++) begin
            spi_read(6'(8 + $urandom % 56), data);              // 0x08 to 0x3F
            check_value("rd_data", int'(data), 0);
        end

        // Register readback
        for (int a = 1; a <= 5; a++) begin
            written[a] = 8'($urandom);
            spi_write(6'(a), written[a]);
        end
        for (int a = 1; a <= 5; a++) begin
            spi_read(6'(a), data);
            check_value("rd_data", int'(data), int'(written[a]));
        end
        spi_write(ADDR_ID, 8'($urandom));                       // Read only
        spi_read(ADDR_ID, data);
        check_value("rd_data", int'(data), int'(SUBSYSTEM_ID));
        sr_fault = 4'($urandom);
        spi_write(ADDR_FAULT_STATUS, 8'($urandom));
        spi_read(ADDR_FAULT_STATUS, data);
        check_value("rd_data", int'(data), int'(sr_fault));
        sr_fault = '0;
        spi_write(ADDR_STATUS_CONTROL, 8'h00);

        // Direct wrist and grabber channels
        for (ch = 1; ch < NUM_SERVOS; ch += 2) begin
            pos = 8'(1 + $urandom % 254);
            spi_write(ADDR_SERVO_POSITION0 + 6'(ch), pos);
            spi_write(ADDR_SERVO_CONTROL, 8'(1 << ch));
            measure_pulse(ch, width[0]);                        // First full period
            for (int k = 1; k < 3; k++) begin
                measure_pulse(ch, width[k]);
                check_value("servo_pwm width", width[k], int'(pos) * PRESCALE);
            end
            spi_write(ADDR_SERVO_CONTROL, 8'h00);
            check_value("servo_pwm", int'(servo_pwm), 0);
        end

        // Ramped base and centre channels
        for (ch = 0; ch < NUM_SERVOS; ch += 2) begin
            pos = 8'(int'(SERVO_START_RATIO) + 2 + $urandom % 7);  // At least two steps
            spi_write(ADDR_SERVO_POSITION0 + 6'(ch), pos);
            spi_write(ADDR_SERVO_CONTROL, 8'(1 << ch));
            for (int k = 0; k < RAMP_PULSES; k++)
                measure_pulse(ch, width[k]);
            for (int k = 0; k < RAMP_PULSES; k++) begin
                ratio = int'(SERVO_START_RATIO) + 1 + k;        // One step per period
                if (ratio > int'(pos))
                    ratio = int'(pos);
                check_value("servo_pwm width", width[k], ratio * PRESCALE);
            end
            spi_write(ADDR_SERVO_CONTROL, 8'h00);
            check_value("servo_pwm", int'(servo_pwm), 0);
        end

        // LED selection in normal mode and then test mode
        for (int k = 0; k < 4; k++) begin
            ctrl = 8'($urandom) & 8'h06;                        // Pi and PS4 bits only
            spi_write(ADDR_STATUS_CONTROL, ctrl);
            sr_fault = (k % 2 == 1) ? 4'($urandom % 15 + 1) : 4'h0;
            wait_fault_led(|sr_fault);
            check_value("status_pi", int'(status_pi), int'(ctrl[STATUS_PI]));
            check_value("status_ps4", int'(status_ps4), int'(ctrl[STATUS_PS4]));
            check_value("status_debug", int'(status_debug), 1);
        end
        for (int k = 0; k < 4; k++) begin
            ctrl = (8'($urandom) & 8'h1E) | 8'h01;              // Test bit set
            spi_write(ADDR_STATUS_CONTROL, ctrl);
            sr_fault = 4'($urandom);
            repeat (3) @(negedge clock);                        // Past the sync lag
            check_value("status_fault", int'(status_fault), int'(ctrl[STATUS_FAULT_LED]));
            check_value("status_pi", int'(status_pi), 1);
            check_value("status_ps4", int'(status_ps4), 1);
            check_value("status_debug", int'(status_debug), int'(ctrl[STATUS_MOTOR_HOT]));
        end

        $display("Errors: %0d wrong values, %0d timeouts", check_errors, timeout_errors);
        if (check_errors == 0 && timeout_errors == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

// File: hdl/fpga_subsystem.sv
`timescale 1ns/1ns
// Arm-servo subsystem top with the SPI target, register file and servo bank
module fpga_subsystem
    import fpga_subsystem_pkg::*;
(
    input  logic                  clock,        // System clock
    input  logic                  reset_n,      // Async reset, active low
    input  logic                  spi_clock,    // SPI clock from host
    input  logic                  cs_n,         // SPI chip select
    input  logic                  mosi,         // SPI data in
    output logic                  miso,         // SPI data out
    input  logic [NUM_SERVOS-1:0] sr_fault,     // Rotation motor faults
    output logic [NUM_SERVOS-1:0] servo_pwm,    // Arm servo PWM
    output logic                  status_fault, // Fault LED
    output logic                  status_pi,    // Orange Pi LED
    output logic                  status_ps4,   // PS4 LED
    output logic                  status_debug  // Debug LED
);

    logic [ADDR_WIDTH-1:0] address;             // Register bus
    logic                  write_en;
    logic [DATA_WIDTH-1:0] wr_data;
    logic                  read_en;
    logic [DATA_WIDTH-1:0] rd_data;
    logic [NUM_SERVOS-1:0] servo_enable;        // Servo levels
    logic [DATA_WIDTH-1:0] servo_position0;
    logic [DATA_WIDTH-1:0] servo_position1;
    logic [DATA_WIDTH-1:0] servo_position2;
    logic [DATA_WIDTH-1:0] servo_position3;

    //////////////////////////////
    // Host access
    //////////////////////////////
    spi_target u_spi_target (
        .clock     (clock),
        .reset_n   (reset_n),
        .spi_clock (spi_clock),
        .cs_n      (cs_n),
        .mosi      (mosi),
        .miso      (miso),
        .address   (address),
        .write_en  (write_en),
        .wr_data   (wr_data),
        .read_en   (read_en),
        .rd_data   (rd_data)
    );

    reg_file u_reg_file (
        .clock           (clock),
        .reset_n         (reset_n),
        .address         (address),
        .write_en        (write_en),
        .wr_data         (wr_data),
        .read_en         (read_en),
        .sr_fault        (sr_fault),
        .rd_data         (rd_data),
        .servo_enable    (servo_enable),
        .servo_position0 (servo_position0),
        .servo_position1 (servo_position1),
        .servo_position2 (servo_position2),
        .servo_position3 (servo_position3),
        .status_fault    (status_fault),
        .status_pi       (status_pi),
        .status_ps4      (status_ps4),
        .status_debug    (status_debug)
    );

    //////////////////////////////
    // Servos
    //////////////////////////////
    servo_bank u_servo_bank (
        .clock           (clock),
        .reset_n         (reset_n),
        .servo_enable    (servo_enable),
        .servo_position0 (servo_position0),
        .servo_position1 (servo_position1),
        .servo_position2 (servo_position2),
        .servo_position3 (servo_position3),
        .servo_pwm       (servo_pwm)
    );

endmodule

// File: hdl/fpga_subsystem_pkg.sv
// Register map, field widths and servo timing constants
// shared by the arm-servo subsystem
package fpga_subsystem_pkg;

    //////////////////////////////
    // Widths
    //////////////////////////////
    localparam int ADDR_WIDTH = 6;                  // Register address bits
    localparam int DATA_WIDTH = 8;                  // Register data bits
    localparam int NUM_SERVOS = 4;                  // Arm servo channels

    //////////////////////////////
    // Register map
    //////////////////////////////
    localparam logic [ADDR_WIDTH-1:0] ADDR_SERVO_CONTROL   = 6'h00;  // Enables in 3:0
    localparam logic [ADDR_WIDTH-1:0] ADDR_SERVO_POSITION0 = 6'h01;  // Positions 1-3 follow
    localparam logic [ADDR_WIDTH-1:0] ADDR_STATUS_CONTROL  = 6'h05;  // LED control bits
    localparam logic [ADDR_WIDTH-1:0] ADDR_FAULT_STATUS    = 6'h06;  // Read only
    localparam logic [ADDR_WIDTH-1:0] ADDR_ID              = 6'h07;  // Read only

    localparam logic [DATA_WIDTH-1:0] SUBSYSTEM_ID = 8'hA5;  // Identity byte

    // Bit positions in the status-control register
    localparam int STATUS_LED_TEST  = 0;            // LED test mode
    localparam int STATUS_PI        = 1;            // Orange Pi connected
    localparam int STATUS_PS4       = 2;            // PS4 pad connected
    localparam int STATUS_FAULT_LED = 3;            // Fault LED in test mode
    localparam int STATUS_MOTOR_HOT = 4;            // Debug LED in test mode

    //////////////////////////////
    // Servo and SPI timing
    //////////////////////////////
    localparam int unsigned SERVO_PRESCALE_DEFAULT = 32'd4;  // Clocks per PWM tick
    localparam logic [DATA_WIDTH-1:0] SERVO_START_RATIO = 8'd5;  // Ramp start point
    localparam logic [NUM_SERVOS-1:0] RAMPED_SERVOS = 4'b0101;   // Base and centre
    localparam logic [4:0] SPI_FRAME_BITS = 5'd16;  // Command byte plus data byte

endpackage

// File: hdl/reg_file.sv
`timescale 1ns/1ns
// Register file with address decode, servo and LED registers,
// fault-input synchroniser and status-LED selection
module reg_file
    import fpga_subsystem_pkg::*;
(
    input  logic                  clock,            // System clock
    input  logic                  reset_n,          // Async reset, active low
    input  logic [ADDR_WIDTH-1:0] address,          // Register address
    input  logic                  write_en,         // Write strobe
    input  logic [DATA_WIDTH-1:0] wr_data,          // Write data
    input  logic                  read_en,          // Read strobe
    input  logic [NUM_SERVOS-1:0] sr_fault,         // Rotation motor faults
    output logic [DATA_WIDTH-1:0] rd_data,          // Read data, one clock later
    output logic [NUM_SERVOS-1:0] servo_enable,     // Per-channel enables
    output logic [DATA_WIDTH-1:0] servo_position0,  // Base target
    output logic [DATA_WIDTH-1:0] servo_position1,  // Wrist target
    output logic [DATA_WIDTH-1:0] servo_position2,  // Centre target
    output logic [DATA_WIDTH-1:0] servo_position3,  // Grabber target
    output logic                  status_fault,     // Fault LED
    output logic                  status_pi,        // Orange Pi LED
    output logic                  status_ps4,       // PS4 LED
    output logic                  status_debug      // Debug LED
);

    logic [DATA_WIDTH-1:0] servo_control;
    logic [DATA_WIDTH-1:0] position [NUM_SERVOS];
    logic [DATA_WIDTH-1:0] status_control;
    logic [NUM_SERVOS-1:0] fault_meta;              // First sync stage
    logic [NUM_SERVOS-1:0] fault_sync;              // Second sync stage
    logic [DATA_WIDTH-1:0] read_mux;
    logic                  led_test;

    //////////////////////////////
    // Writes
    //////////////////////////////
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            servo_control  <= '0;
            status_control <= '0;
            for (int i = 0; i < NUM_SERVOS; i++)
                position[i] <= '0;
        end else if (write_en) begin
            if (address == ADDR_SERVO_CONTROL)
                servo_control <= wr_data;
            if (address == ADDR_STATUS_CONTROL)
                status_control <= wr_data;
            for (int i = 0; i < NUM_SERVOS; i++)
                if (address == ADDR_SERVO_POSITION0 + ADDR_WIDTH'(i))
                    position[i] <= wr_data;
        end                                     // Read-only and unmapped ignored
    end

    //////////////////////////////
    // Reads
    //////////////////////////////
    always_comb begin
        read_mux = '0;                          // Unmapped reads as zero
        case (address)
            ADDR_SERVO_CONTROL:  read_mux = servo_control;
            ADDR_STATUS_CONTROL: read_mux = status_control;
            ADDR_FAULT_STATUS:   read_mux = {{(DATA_WIDTH-NUM_SERVOS){1'b0}}, fault_sync};
            ADDR_ID:             read_mux = SUBSYSTEM_ID;
            default:             read_mux = '0;
        endcase
        for (int i = 0; i < NUM_SERVOS; i++)
            if (address == ADDR_SERVO_POSITION0 + ADDR_WIDTH'(i))
                read_mux = position[i];
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            rd_data    <= '0;
            fault_meta <= '0;
            fault_sync <= '0;
        end else begin
            if (read_en)
                rd_data <= read_mux;            // Held until next read
            fault_meta <= sr_fault;             // Two-clock lag
            fault_sync <= fault_meta;
        end
    end

    assign servo_enable    = servo_control[NUM_SERVOS-1:0];
    assign servo_position0 = position[0];
    assign servo_position1 = position[1];
    assign servo_position2 = position[2];
    assign servo_position3 = position[3];

    // Test mode forces the whole LED panel
    assign led_test     = status_control[STATUS_LED_TEST];
    assign status_fault = led_test ? status_control[STATUS_FAULT_LED] : |fault_sync;
    assign status_pi    = led_test | status_control[STATUS_PI];
    assign status_ps4   = led_test | status_control[STATUS_PS4];
    assign status_debug = led_test ? status_control[STATUS_MOTOR_HOT] : 1'b1;

endmodule

// File: hdl/servo_bank.sv
`timescale 1ns/1ns
// Servo bank with a shared prescaler and period counter, per-channel
// ratio latch with optional ramp, and the PWM comparators
module servo_bank
    import fpga_subsystem_pkg::*;
#(
    parameter int unsigned SERVO_PRESCALE = SERVO_PRESCALE_DEFAULT  // Clocks per tick
) (
    input  logic                  clock,            // System clock
    input  logic                  reset_n,          // Async reset, active low
    input  logic [NUM_SERVOS-1:0] servo_enable,     // Channel enables
    input  logic [DATA_WIDTH-1:0] servo_position0,  // Base target
    input  logic [DATA_WIDTH-1:0] servo_position1,  // Wrist target
    input  logic [DATA_WIDTH-1:0] servo_position2,  // Centre target
    input  logic [DATA_WIDTH-1:0] servo_position3,  // Grabber target
    output logic [NUM_SERVOS-1:0] servo_pwm         // PWM outputs
);

    localparam int PRE_WIDTH = (SERVO_PRESCALE > 1) ? $clog2(SERVO_PRESCALE) : 1;
    localparam logic [PRE_WIDTH-1:0] PRE_LAST = PRE_WIDTH'(SERVO_PRESCALE - 1);

    logic [PRE_WIDTH-1:0]  pre_cnt;                 // Clocks within a tick
    logic                  tick;
    logic [DATA_WIDTH-1:0] period_cnt;              // Ticks 0 to 255
    logic                  period_start;            // Next clock is count 0
    logic [DATA_WIDTH-1:0] position [NUM_SERVOS];

    assign position[0] = servo_position0;
    assign position[1] = servo_position1;
    assign position[2] = servo_position2;
    assign position[3] = servo_position3;

    //////////////////////////////
    // Shared time base
    //////////////////////////////
    assign tick         = (pre_cnt == PRE_LAST);
    assign period_start = tick & (&period_cnt);

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            pre_cnt    <= '0;
            period_cnt <= '0;
        end else begin
            pre_cnt <= tick ? '0 : pre_cnt + 1'b1;
            if (tick)
                period_cnt <= period_cnt + 1'b1;   // Wraps at 256
        end
    end

    //////////////////////////////
    // Channels
    //////////////////////////////
    for (genvar ch = 0; ch < NUM_SERVOS; ch++) begin : g_channel
        logic [DATA_WIDTH-1:0] ratio;               // Active high time in ticks

        if (RAMPED_SERVOS[ch]) begin : g_ramp
            // Base and centre creep one step per period
            always_ff @(posedge clock or negedge reset_n) begin
                if (!reset_n) begin
                    ratio <= SERVO_START_RATIO;
                end else if (!servo_enable[ch]) begin
                    ratio <= SERVO_START_RATIO;     // Restart ramp on re-enable
                end else if (period_start) begin
                    if (ratio < position[ch])
                        ratio <= ratio + 1'b1;
                    else if (ratio > position[ch])
                        ratio <= ratio - 1'b1;
                end
            end
        end else begin : g_direct
            always_ff @(posedge clock or negedge reset_n) begin
                if (!reset_n)
                    ratio <= '0;
                else if (!servo_enable[ch])
                    ratio <= '0;                    // No stale pulse on re-enable
                else if (period_start)
                    ratio <= position[ch];          // New target each period
            end
        end

        // High for ratio ticks from count 0
        assign servo_pwm[ch] = servo_enable[ch] & (period_cnt < ratio);
    end

endmodule

// File: hdl/spi_target.sv
`timescale 1ns/1ns
// SPI mode-0 target with pin synchronisers, 16-bit frame decode,
// register read/write strobes and the read-data shifter
module spi_target
    import fpga_subsystem_pkg::*;
(
    input  logic                  clock,        // System clock
    input  logic                  reset_n,      // Async reset, active low
    input  logic                  spi_clock,    // SPI clock pin
    input  logic                  cs_n,         // Chip select pin, active low
    input  logic                  mosi,         // Data from host
    output logic                  miso,         // Data to host
    output logic [ADDR_WIDTH-1:0] address,      // Register address
    output logic                  write_en,     // One-cycle write strobe
    output logic [DATA_WIDTH-1:0] wr_data,      // Write data
    output logic                  read_en,      // One-cycle read strobe
    input  logic [DATA_WIDTH-1:0] rd_data       // Registered read data
);

    localparam logic [4:0] HALF_FRAME = SPI_FRAME_BITS >> 1;   // Bits per byte
    localparam logic [4:0] CMD_LAST   = HALF_FRAME - 5'd1;     // Edge closing command
    localparam logic [4:0] DATA_LAST  = SPI_FRAME_BITS - 5'd1; // Edge closing data

    logic [2:0]            sclk_q;          // Two sync stages plus history
    logic [1:0]            cs_q;            // Chip select sync
    logic [1:0]            mosi_q;          // Data sync
    logic                  sclk_rise;
    logic                  sclk_fall;
    logic                  frame_active;    // Synchronised cs_n low
    logic [4:0]            bit_cnt;         // Rising edges in this frame
    logic [DATA_WIDTH-2:0] shift_in;        // Earlier bits of current byte
    logic [DATA_WIDTH-1:0] rx_byte;         // Byte as of this edge
    logic                  write_flag;      // Command flag of the frame
    logic                  load_pending;    // rd_data valid this cycle
    logic [DATA_WIDTH-1:0] tx_shift;        // Read data, MSB on miso

    //////////////////////////////
    // Pin synchronisers
    //////////////////////////////
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            sclk_q <= '0;
            cs_q   <= '1;                   // Idle deselected
            mosi_q <= '0;
        end else begin
            sclk_q <= {sclk_q[1:0], spi_clock};
            cs_q   <= {cs_q[0], cs_n};
            mosi_q <= {mosi_q[0], mosi};
        end
    end

    assign sclk_rise    = sclk_q[1] & ~sclk_q[2];
    assign sclk_fall    = ~sclk_q[1] & sclk_q[2];
    assign frame_active = ~cs_q[1];
    assign rx_byte      = {shift_in, mosi_q[1]};   // MSB first

    //////////////////////////////
    // Frame count and strobes
    //////////////////////////////
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            bit_cnt    <= '0;
            write_flag <= 1'b0;
            write_en   <= 1'b0;
            read_en    <= 1'b0;
        end else begin
            write_en <= 1'b0;               // Strobes last one cycle
            read_en  <= 1'b0;
            if (!frame_active) begin
                bit_cnt <= '0;              // Short frame gives no strobe
            end else if (sclk_rise) begin
                if (bit_cnt != SPI_FRAME_BITS)
                    bit_cnt <= bit_cnt + 5'd1;   // Hold after a full frame
                if (bit_cnt == CMD_LAST) begin
                    write_flag <= rx_byte[DATA_WIDTH-1];
                    read_en    <= ~rx_byte[DATA_WIDTH-1];
                end
                if (bit_cnt == DATA_LAST)
                    write_en <= write_flag;
            end
        end
    end

    // Received bytes
    always_ff @(posedge clock) begin
        if (frame_active && sclk_rise) begin
            shift_in <= rx_byte[DATA_WIDTH-2:0];
            if (bit_cnt == CMD_LAST)
                address <= rx_byte[ADDR_WIDTH-1:0];   // Bit 6 is reserved
            if (bit_cnt == DATA_LAST)
                wr_data <= rx_byte;
        end
    end

    //////////////////////////////
    // Read data out
    //////////////////////////////
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            load_pending <= 1'b0;
            tx_shift     <= '0;
        end else begin
            load_pending <= read_en;
            if (load_pending)
                tx_shift <= rd_data;        // Ready before the 9th rise
            else if (frame_active && sclk_fall && bit_cnt > HALF_FRAME)
                tx_shift <= {tx_shift[DATA_WIDTH-2:0], 1'b0};
        end
    end

    assign miso = ~cs_n & tx_shift[DATA_WIDTH-1];   // Quiet when deselected

endmodule

// File: run.sh
#!/bin/sh
# Build and run the subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert -f tb.f --top-module tb_fpga_subsystem -o sim_tb
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q '\*\* FAIL \*\*' "$LOG"; then
    echo "Testbench reported failure"
    exit 1
fi
exit 0

// File: tb.f
hdl/fpga_subsystem_pkg.sv
hdl/spi_target.sv
hdl/reg_file.sv
hdl/servo_bank.sv
hdl/fpga_subsystem.sv
dv/fpga_subsystem_checker.sv
dv/tb_fpga_subsystem.sv
